// File: run_sim.sh
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_vic_loader -f vic_loader.f

./obj_dir/Vtb_vic_loader | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run_sim: testbench reported failure"
	exit 1
fi

echo "run_sim: testbench finished without failure"
exit 0

// File: sim/tb_vic_checker.sv
`default_nettype none
`include "vic_loader_cfg.svh"

module tb_vic_checker (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  vic_loader_pkg::dl_stream_t dl_i,
	input  vic_loader_pkg::mem_wr_t    mem_wr_i,
	input  logic [`APB_ADDR_W-1:0]     paddr_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  vic_loader_pkg::byte_t      pwdata_i,
	input  vic_loader_pkg::byte_t      prdata_i,
	input  logic                       pready_i,
	input  logic                       pslverr_i,
	input  vic_loader_pkg::blk_mask_t  ram_ext_i,
	input  vic_loader_pkg::blk_mask_t  ram_ext_ro_i,
	output int                         pending_o,
	output int                         value_errs_o,
	output int                         missing_errs_o,
	output int                         extra_errs_o
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [31:0]           due;
		vic_loader_pkg::addr_t addr;
		vic_loader_pkg::byte_t data;
	} exp_wr_t;

	typedef struct packed {
		logic                      wr;
		vic_loader_pkg::addr_t     addr;
		vic_loader_pkg::addr_t     next;
		vic_loader_pkg::blk_mask_t blk;
	} ref_out_t;

	string                     test_name = "none";
	exp_wr_t                   exp_q[$];
	exp_wr_t                   head;
	ref_out_t                  r;
	logic [31:0]               tick;
	logic                      prev_dl;
	logic [4:0]                opt_shadow;
	int                        k;
	vic_loader_pkg::addr_t     ref_addr;
	vic_loader_pkg::blk_mask_t exp_blk;
	vic_loader_pkg::blk_mask_t exp_ext;
	vic_loader_pkg::blk_mask_t exp_ro;
	vic_loader_pkg::byte_t     exp_rd;

	////////////////////////////////////////
	// Reference model

	// Expected loader write for one stream beat at running address cur
	function automatic ref_out_t ref_write(vic_loader_pkg::dl_stream_t beat,
		vic_loader_pkg::addr_t cur);
		ref_out_t              o;
		vic_loader_pkg::addr_t limit;
		o      = '0;
		o.addr = cur;
		o.next = cur;
		limit  = (beat.index == `IDX_PRG) ? `PRG_LIMIT : `CART_LIMIT;
		if (beat.index == `IDX_ROM) begin
			o.wr   = (beat.ofs >= vic_loader_pkg::ioctl_ofs_t'(`ROM_WIN_LO)) &&
				(beat.ofs < vic_loader_pkg::ioctl_ofs_t'(`ROM_WIN_HI));
			o.addr = beat.ofs[15:0] + `ROM_OFFSET;
		end else if (beat.index > `IDX_CART_RAW) begin
			o.wr = 1'b0;
		end else if ((beat.index != `IDX_CART_RAW) && (beat.ofs < 25'd2)) begin
			// Little-endian load address
			if (beat.ofs[0])
				o.next[15:8] = beat.data;
			else
				o.next[7:0] = beat.data;
		end else if (cur < limit) begin
			o.wr   = 1'b1;
			o.next = cur + 16'd1;
			if (beat.index != `IDX_PRG) begin
				if (cur[15:13] <= 3'd3)
					o.blk = 5'b00001 << cur[15:13];
				else if (cur[15:13] == 3'd5)
					o.blk = 5'b10000;
			end
		end
		return o;
	endfunction

	// Raw cart start from the last extension character
	function automatic vic_loader_pkg::addr_t raw_start_addr(vic_loader_pkg::byte_t ext,
		vic_loader_pkg::addr_t cur);
		if ((ext >= "2") && (ext <= "9"))
			return 16'h1000 * {8'h00, ext - "0"};
		if (ext == "A")
			return 16'hA000;
		if (ext == "B")
			return 16'hB000;
		return cur;
	endfunction

	// Low byte of each interpreter pointer pair
	function automatic vic_loader_pkg::addr_t ptr_base(int idx);
		case (idx)
			0:       return 16'h002D;
			1:       return 16'h002F;
			2:       return 16'h0031;
			default: return 16'h00AE;
		endcase
	endfunction

	task automatic queue_write(logic [31:0] due, vic_loader_pkg::addr_t addr,
		vic_loader_pkg::byte_t data);
		exp_wr_t e;
		e.due  = due;
		e.addr = addr;
		e.data = data;
		exp_q.push_back(e);
	endtask

	////////////////////////////////////////
	// Comparison, sampled mid-cycle

	always @(negedge clk_sys) begin
		if (reset) begin
			exp_q.delete();
			tick           = '0;
			prev_dl        = 1'b0;
			opt_shadow     = '0;
			ref_addr       = '0;
			exp_blk        = '0;
			value_errs_o   = 0;
			missing_errs_o = 0;
			extra_errs_o   = 0;
		end else begin
			tick = tick + 32'd1;

			// Memory writes leave the DUT in stream order
			if (mem_wr_i.wr) begin
				if (exp_q.size() == 0) begin
					extra_errs_o++;
					$display("Unexpected memory write %h = %h in test %s",
						mem_wr_i.addr, mem_wr_i.data, test_name);
				end else begin
					head = exp_q.pop_front();
					if ((head.addr != mem_wr_i.addr) || (head.data != mem_wr_i.data)) begin
						value_errs_o++;
						$display("[FAIL] %s: memory write expected %h = %h, actual %h = %h",
							test_name, head.addr, head.data, mem_wr_i.addr, mem_wr_i.data);
					end
				end
			end
			while ((exp_q.size() != 0) && (exp_q[0].due < tick)) begin
				missing_errs_o++;
				$display("Memory write %h = %h never appeared in test %s",
					exp_q[0].addr, exp_q[0].data, test_name);
				exp_q.delete(0);
			end

			// Masks reflect options and blocks from before this cycle
			exp_ext = {opt_shadow[3], 3'b000, opt_shadow[0]} | exp_blk;
			if (opt_shadow[2:1] != 2'd0)
				exp_ext[1] = 1'b1;
			if (opt_shadow[2])
				exp_ext[2] = 1'b1;
			if (opt_shadow[2:1] == 2'd3)
				exp_ext[3] = 1'b1;
			exp_ro = opt_shadow[4] ? 5'b00000 : exp_blk;
			if (ram_ext_i != exp_ext) begin
				value_errs_o++;
				$display("[FAIL] %s: ram_ext_o expected %b, actual %b",
					test_name, exp_ext, ram_ext_i);
			end
			if (ram_ext_ro_i != exp_ro) begin
				value_errs_o++;
				$display("[FAIL] %s: ram_ext_ro_o expected %b, actual %b",
					test_name, exp_ro, ram_ext_ro_i);
			end

			// APB access phase
			if (psel_i && penable_i) begin
				if (pready_i !== 1'b1) begin
					value_errs_o++;
					$display("[FAIL] %s: pready_o expected 1, actual %b",
						test_name, pready_i);
				end
				if (pslverr_i !== 1'b0) begin
					value_errs_o++;
					$display("[FAIL] %s: pslverr_o expected 0, actual %b",
						test_name, pslverr_i);
				end
			end
			if (psel_i && penable_i && pwrite_i && (paddr_i == 'h0)) begin
				opt_shadow = pwdata_i[4:0];
			end else if (psel_i && penable_i && !pwrite_i) begin
				exp_rd = 8'h00;
				if (paddr_i == 'h0)
					exp_rd = {3'b000, opt_shadow};
				else if (paddr_i == 'h1)
					exp_rd = {3'b000, exp_blk};
				if (prdata_i != exp_rd) begin
					value_errs_o++;
					$display("[FAIL] %s: register %0d expected %h, actual %h",
						test_name, paddr_i, exp_rd, prdata_i);
				end
			end

			// Download stream
			if (dl_i.download && !prev_dl && (dl_i.index == `IDX_CART_RAW))
				ref_addr = raw_start_addr(dl_i.ext, ref_addr);
			if (dl_i.download && dl_i.wr) begin
				r        = ref_write(dl_i, ref_addr);
				ref_addr = r.next;
				exp_blk  = exp_blk | r.blk;
				if (r.wr)
					queue_write(tick + 32'd1, r.addr, dl_i.data);
			end
			// Pointer bytes follow a program load, one every second cycle
			if (prev_dl && !dl_i.download && (dl_i.index == `IDX_PRG)) begin
				for (k = 0; k < 4; k++) begin
					queue_write(tick + 32'(2 + 4 * k), ptr_base(k), ref_addr[7:0]);
					queue_write(tick + 32'(4 + 4 * k), ptr_base(k) + 16'd1, ref_addr[15:8]);
				end
			end
			prev_dl   = dl_i.download;
			pending_o = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_vic_loader.sv
`default_nettype none
`include "vic_loader_cfg.svh"

module tb_vic_loader;
	timeunit 1ns;
	timeprecision 100ps;

	// Download bytes of all images, headers included
	localparam int dl_bytes    = 42 + 12 + 32'h8000 + 8194 + 64;
	// Three cycles per byte, a drain per image, APB accesses of two option sweeps
	localparam int stim_cycles = 3 * dl_bytes + 5 * 40 + 2 * 35 * 3 * 4 + 100;
	localparam int cycle_limit = 2 * stim_cycles;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	vic_loader_pkg::dl_stream_t dl;
	logic [`APB_ADDR_W-1:0]    paddr;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	vic_loader_pkg::byte_t     pwdata;
	vic_loader_pkg::byte_t     prdata;
	logic                      pready;
	logic                      pslverr;
	vic_loader_pkg::mem_wr_t   mem_wr;
	vic_loader_pkg::blk_mask_t ram_ext;
	vic_loader_pkg::blk_mask_t ram_ext_ro;
	logic [31:0]               rnd;
	int                        cyc = 0;
	int                        pending;
	int                        value_errs;
	int                        missing_errs;
	int                        extra_errs;

	always #5 clk_sys = ~clk_sys;

	vic_loader_top uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_i         (dl),
		.paddr_i      (paddr),
		.psel_i       (psel),
		.penable_i    (penable),
		.pwrite_i     (pwrite),
		.pwdata_i     (pwdata),
		.prdata_o     (prdata),
		.pready_o     (pready),
		.pslverr_o    (pslverr),
		.mem_wr_o     (mem_wr),
		.ram_ext_o    (ram_ext),
		.ram_ext_ro_o (ram_ext_ro)
	);

	tb_vic_checker chk (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_i           (dl),
		.mem_wr_i       (mem_wr),
		.paddr_i        (paddr),
		.psel_i         (psel),
		.penable_i      (penable),
		.pwrite_i       (pwrite),
		.pwdata_i       (pwdata),
		.prdata_i       (prdata),
		.pready_i       (pready),
		.pslverr_i      (pslverr),
		.ram_ext_i      (ram_ext),
		.ram_ext_ro_i   (ram_ext_ro),
		.pending_o      (pending),
		.value_errs_o   (value_errs),
		.missing_errs_o (missing_errs),
		.extra_errs_o   (extra_errs)
	);

	function automatic logic [31:0] next_rand(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// Bus tasks

	// Waits until every expected write has shown up, bounded
	task automatic wait_drain();
		int spins;
		spins = 0;
		repeat (2) @(posedge clk_sys);
		while ((pending != 0) && (spins < 64)) begin
			@(posedge clk_sys);
			spins++;
		end
		repeat (4) @(posedge clk_sys);
	endtask

	// One write every third cycle, header bytes first when present
	task automatic load_image(input vic_loader_pkg::ioctl_idx_t idx,
		input vic_loader_pkg::byte_t ext, input vic_loader_pkg::addr_t hdr_addr,
		input logic with_hdr, input int n_payload);
		int n_total;
		int ofs;
		n_total = with_hdr ? n_payload + 2 : n_payload;
		@(posedge clk_sys);
		#1;
		dl.download = 1'b1;
		dl.index    = idx;
		dl.ext      = ext;
		for (ofs = 0; ofs < n_total; ofs++) begin
			@(posedge clk_sys);
			#1;
			if (with_hdr && (ofs == 0)) begin
				dl.data = hdr_addr[7:0];
			end else if (with_hdr && (ofs == 1)) begin
				dl.data = hdr_addr[15:8];
			end else begin
				rnd     = next_rand(rnd);
				dl.data = rnd[7:0];
			end
			dl.ofs = vic_loader_pkg::ioctl_ofs_t'(ofs);
			dl.wr  = 1'b1;
			@(posedge clk_sys);
			#1;
			dl.wr = 1'b0;
			@(posedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		dl.download = 1'b0;
		wait_drain();
	endtask

	task automatic apb_access(input logic [`APB_ADDR_W-1:0] addr, input logic wr,
		input vic_loader_pkg::byte_t data);
		@(posedge clk_sys);
		#1;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk_sys);
		#1;
		penable = 1'b1;
		@(posedge clk_sys);
		while (!pready)
			@(posedge clk_sys);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input vic_loader_pkg::byte_t data);
		apb_access(addr, 1'b1, data);
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr);
		apb_access(addr, 1'b0, 8'h00);
	endtask

	// Every RAM2 code with every combination of RAM1, RAM3 and cart write
	task automatic option_sweep();
		int code;
		int flags;
		// Bit order cart_wr, ram3, ram2 code, ram1
		for (code = 0; code < 4; code++) begin
			for (flags = 0; flags < 8; flags++) begin
				apb_write(4'h0, {3'b000, flags[2], flags[1], code[1:0], flags[0]});
				apb_read(4'h0);
				apb_read(4'h1);
			end
		end
		apb_write(4'h0, 8'h00);
	endtask

	////////////////////////////////////////
	// Run control

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_limit);
			$display("Errors: value %0d, missing %0d, extra %0d",
				value_errs, missing_errs, extra_errs);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		reset   = 1'b1;
		dl      = '0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		rnd     = 32'd85401;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;

		chk.test_name = "prg_load";
		load_image(`IDX_PRG, "P", 16'h9FF0, 1'b1, 40);
		chk.test_name = "ptr_patch";
		load_image(`IDX_PRG, "P", 16'h1001, 1'b1, 10);
		chk.test_name = "rom_load";
		load_image(`IDX_ROM, "M", 16'h0000, 1'b0, 32'h8000);

		// No cart blocks yet, so every option bit shows in ram_ext_o
		chk.test_name = "apb_options";
		option_sweep();

		chk.test_name = "cart_hdr";
		load_image(`IDX_CART_HDR, "T", 16'hA000, 1'b1, 8192);
		apb_read(4'h1);
		chk.test_name = "cart_raw";
		load_image(`IDX_CART_RAW, "6", 16'h0000, 1'b0, 64);
		apb_read(4'h1);

		// Cart blocks present, so the write permission shows in ram_ext_ro_o
		chk.test_name = "apb_options_cart";
		option_sweep();
		repeat (4) @(posedge clk_sys);

		$display("Errors: value %0d, missing %0d, extra %0d",
			value_errs, missing_errs, extra_errs);
		if ((value_errs + missing_errs + extra_errs) == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/basic_ptr_patcher.sv
`default_nettype none

module basic_ptr_patcher (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  vic_loader_pkg::mem_wr_t ld_wr_i,
	input  logic                    prg_done_i,
	input  vic_loader_pkg::addr_t   prg_end_i,
	input  logic                    dl_active_i,
	output vic_loader_pkg::mem_wr_t mem_wr_o
);

	vic_loader_pkg::patch_state_t state;
	vic_loader_pkg::addr_t        end_q;
	vic_loader_pkg::addr_t        ld_addr_q;
	vic_loader_pkg::byte_t        ld_data_q;
	vic_loader_pkg::addr_t        ptr_addr;
	logic                         ld_wr_q;
	logic                         ptr_wr;
	logic                         ptr_hi;

	always_ff @(posedge clk_sys) begin
		if (reset)
			ld_wr_q <= 1'b0;
		else
			ld_wr_q <= ld_wr_i.wr;
	end

	always_ff @(posedge clk_sys) begin
		ld_addr_q <= ld_wr_i.addr;
		ld_data_q <= ld_wr_i.data;
		if ((state == vic_loader_pkg::p_idle) && prg_done_i)
			end_q <= prg_end_i;
	end

	////////////////////////////////////////
	// Patch sequence

	// Any new download aborts the sequence
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i)
			state <= vic_loader_pkg::p_idle;
		else if (state == vic_loader_pkg::p_idle) begin
			if (prg_done_i)
				state <= vic_loader_pkg::p_wr0;
		end else if (state == vic_loader_pkg::p_gap7)
			state <= vic_loader_pkg::p_idle;
		else
			state <= vic_loader_pkg::patch_state_t'(state + 5'd1);
	end

	// BASIC start of variables, arrays, end of arrays and end of program
	always_comb begin
		ptr_wr   = 1'b1;
		ptr_hi   = 1'b0;
		ptr_addr = 16'h002D;
		case (state)
			vic_loader_pkg::p_wr0: ptr_addr = 16'h002D;
			vic_loader_pkg::p_wr1: begin
				ptr_addr = 16'h002E;
				ptr_hi   = 1'b1;
			end
			vic_loader_pkg::p_wr2: ptr_addr = 16'h002F;
			vic_loader_pkg::p_wr3: begin
				ptr_addr = 16'h0030;
				ptr_hi   = 1'b1;
			end
			vic_loader_pkg::p_wr4: ptr_addr = 16'h0031;
			vic_loader_pkg::p_wr5: begin
				ptr_addr = 16'h0032;
				ptr_hi   = 1'b1;
			end
			vic_loader_pkg::p_wr6: ptr_addr = 16'h00AE;
			vic_loader_pkg::p_wr7: begin
				ptr_addr = 16'h00AF;
				ptr_hi   = 1'b1;
			end
			default: ptr_wr = 1'b0;
		endcase
	end

	always_comb begin
		if (state == vic_loader_pkg::p_idle) begin
			mem_wr_o.wr   = ld_wr_q;
			mem_wr_o.addr = ld_addr_q;
			mem_wr_o.data = ld_data_q;
		end else begin
			mem_wr_o.wr   = ptr_wr;
			mem_wr_o.addr = ptr_addr;
			mem_wr_o.data = ptr_hi ? end_q[15:8] : end_q[7:0];
		end
	end

endmodule

`default_nettype wire

// File: src/image_loader.sv
`default_nettype none
`include "vic_loader_cfg.svh"

module image_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  vic_loader_pkg::dl_stream_t dl_i,
	output vic_loader_pkg::mem_wr_t    ld_wr_o,
	output logic                       prg_done_o,
	output vic_loader_pkg::addr_t      prg_end_o,
	output vic_loader_pkg::blk_mask_t  cart_blk_o
);

	vic_loader_pkg::addr_t     addr_q;
	vic_loader_pkg::addr_t     seed_addr;
	vic_loader_pkg::addr_t     cur_addr;
	vic_loader_pkg::blk_mask_t blk_q;
	vic_loader_pkg::blk_mask_t blk_set;
	logic                      old_dl;
	logic                      is_rom;
	logic                      is_prg;
	logic                      is_cart;
	logic                      has_hdr;
	logic                      hdr_wr;
	logic                      raw_start;
	logic                      rom_hit;
	logic                      prg_hit;
	logic                      cart_hit;

	////////////////////////////////////////
	// Stream decode

	assign is_rom  = dl_i.download && (dl_i.index == `IDX_ROM);
	assign is_prg  = dl_i.download && (dl_i.index == `IDX_PRG);
	assign is_cart = dl_i.download &&
		((dl_i.index == `IDX_CART_HDR) || (dl_i.index == `IDX_CART_RAW));

	// Programs and headered carts carry a little-endian load address
	assign has_hdr   = (dl_i.index == `IDX_PRG) || (dl_i.index == `IDX_CART_HDR);
	assign hdr_wr    = dl_i.download && dl_i.wr && has_hdr && (dl_i.ofs < 2);
	assign raw_start = !old_dl && dl_i.download && (dl_i.index == `IDX_CART_RAW);

	// Start address of a raw cart from the last extension character
	always_comb begin
		seed_addr = addr_q;
		if ((dl_i.ext >= "2") && (dl_i.ext <= "9"))
			seed_addr = {dl_i.ext[3:0], 12'h000};
		else if ((dl_i.ext == "A") || (dl_i.ext == "B"))
			seed_addr = {dl_i.ext[3:0] + 4'd9, 12'h000};
	end

	// A write in the very first beat already uses the seeded address
	assign cur_addr = raw_start ? seed_addr : addr_q;

	assign prg_hit  = is_prg && dl_i.wr && !hdr_wr && (cur_addr < `PRG_LIMIT);
	assign cart_hit = is_cart && dl_i.wr && !hdr_wr && (cur_addr < `CART_LIMIT);
	assign rom_hit  = is_rom && dl_i.wr &&
		(dl_i.ofs >= `ROM_WIN_LO) && (dl_i.ofs < `ROM_WIN_HI);

	always_comb begin
		ld_wr_o.wr   = prg_hit || cart_hit || rom_hit;
		ld_wr_o.addr = rom_hit ? (dl_i.ofs[15:0] + `ROM_OFFSET) : cur_addr;
		ld_wr_o.data = dl_i.data;
	end

	// 8 KB block touched by a cart write
	always_comb begin
		case (cur_addr[15:13])
			3'b000:  blk_set = 5'b00001;
			3'b001:  blk_set = 5'b00010;
			3'b010:  blk_set = 5'b00100;
			3'b011:  blk_set = 5'b01000;
			3'b101:  blk_set = 5'b10000;
			default: blk_set = 5'b00000;
		endcase
	end

	////////////////////////////////////////
	// Address counter and flags

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl     <= 1'b0;
			addr_q     <= '0;
			blk_q      <= '0;
			prg_done_o <= 1'b0;
		end else begin
			old_dl     <= dl_i.download;
			prg_done_o <= old_dl && !dl_i.download && (dl_i.index == `IDX_PRG);
			if (hdr_wr) begin
				if (dl_i.ofs[0])
					addr_q[15:8] <= dl_i.data;
				else
					addr_q[7:0] <= dl_i.data;
			end else if (prg_hit || cart_hit) begin
				addr_q <= cur_addr + 1'b1;
			end else if (raw_start) begin
				addr_q <= seed_addr;
			end
			if (cart_hit)
				blk_q <= blk_q | blk_set;
		end
	end

	// Counter ends one past the last byte written
	assign prg_end_o  = addr_q;
	assign cart_blk_o = blk_q;

endmodule

`default_nettype wire

// File: src/vic_cfg_regs.sv
`default_nettype none
`include "vic_loader_cfg.svh"

module vic_cfg_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [`APB_ADDR_W-1:0]    paddr_i,
	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  vic_loader_pkg::byte_t     pwdata_i,
	input  vic_loader_pkg::blk_mask_t cart_blk_i,
	output vic_loader_pkg::byte_t     prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o,
	output vic_loader_pkg::blk_mask_t ram_ext_o,
	output vic_loader_pkg::blk_mask_t ram_ext_ro_o
);

	localparam logic [`APB_ADDR_W-1:0] reg_opt_addr = 'h0;
	localparam logic [`APB_ADDR_W-1:0] reg_blk_addr = 'h1;

	// Option register layout, bit 4 down to bit 0
	typedef struct packed {
		logic       cart_wr;
		logic       ram3;
		logic [1:0] ram2;
		logic       ram1;
	} opt_t;

	opt_t       opt_q;
	logic [2:0] ram2_blk;
	logic       apb_wr;

	////////////////////////////////////////
	// APB access

	// No wait states and no error response
	assign pready_o  = 1'b1;
	assign pslverr_o = 1'b0;

	assign apb_wr = psel_i && penable_i && pwrite_i;

	always_ff @(posedge clk_sys) begin
		if (reset)
			opt_q <= '0;
		else if (apb_wr && (paddr_i == reg_opt_addr))
			opt_q <= pwdata_i[4:0];
	end

	always_comb begin
		prdata_o = '0;
		if (psel_i && !pwrite_i) begin
			case (paddr_i)
				reg_opt_addr: prdata_o = {3'b000, opt_q};
				reg_blk_addr: prdata_o = {3'b000, cart_blk_i};
				default:      prdata_o = '0;
			endcase
		end
	end

	////////////////////////////////////////
	// Expansion masks

	// RAM2 size code to blocks 1..3, always filled from block 1 upward
	always_comb begin
		case (opt_q.ram2)
			2'd0:    ram2_blk = 3'b000;
			2'd1:    ram2_blk = 3'b001;
			2'd2:    ram2_blk = 3'b011;
			default: ram2_blk = 3'b111;
		endcase
	end

	assign ram_ext_o    = {opt_q.ram3, ram2_blk, opt_q.ram1} | cart_blk_i;
	assign ram_ext_ro_o = opt_q.cart_wr ? '0 : cart_blk_i;

endmodule

`default_nettype wire

// File: src/vic_loader_cfg.svh
`ifndef VIC_LOADER_CFG_SVH
`define VIC_LOADER_CFG_SVH

// Bus widths
`define VIC_ADDR_W    16
`define IOCTL_ADDR_W  25
`define APB_ADDR_W    4

// Write limits, first address that may not be written
`define PRG_LIMIT     16'hA000
`define CART_LIMIT    16'hC000

// System ROM window inside the download stream
`define ROM_WIN_LO    16'h4000
`define ROM_WIN_HI    16'h8000
`define ROM_OFFSET    16'h8000

// Download index codes
`define IDX_ROM       8'd0
`define IDX_PRG       8'd1
`define IDX_CART_HDR  8'd2
`define IDX_CART_RAW  8'd3

`endif

// File: src/vic_loader_pkg.sv
`default_nettype none
`include "vic_loader_cfg.svh"

package vic_loader_pkg;

	typedef logic [`VIC_ADDR_W-1:0]   addr_t;
	typedef logic [7:0]               byte_t;
	typedef logic [7:0]               ioctl_idx_t;
	typedef logic [`IOCTL_ADDR_W-1:0] ioctl_ofs_t;

	// Bit 0 RAM1 at $0400, bits 1..3 blocks at $2000-$7FFF, bit 4 block 5 at $A000
	typedef logic [4:0] blk_mask_t;

	// One beat of the host download channel
	typedef struct packed {
		logic       download;
		ioctl_idx_t index;
		logic       wr;
		ioctl_ofs_t ofs;
		byte_t      data;
		byte_t      ext;
	} dl_stream_t;

	// Configuration memory write
	typedef struct packed {
		logic  wr;
		addr_t addr;
		byte_t data;
	} mem_wr_t;

	// Pointer patch sequence, a write and a gap per pointer byte
	typedef enum logic [4:0] {
		p_idle,
		p_wr0, p_gap0, p_wr1, p_gap1,
		p_wr2, p_gap2, p_wr3, p_gap3,
		p_wr4, p_gap4, p_wr5, p_gap5,
		p_wr6, p_gap6, p_wr7, p_gap7
	} patch_state_t;

endpackage

`default_nettype wire

// File: src/vic_loader_top.sv
`default_nettype none
`include "vic_loader_cfg.svh"

module vic_loader_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  vic_loader_pkg::dl_stream_t dl_i,
	input  logic [`APB_ADDR_W-1:0]     paddr_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  vic_loader_pkg::byte_t      pwdata_i,
	output vic_loader_pkg::byte_t      prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	output vic_loader_pkg::mem_wr_t    mem_wr_o,
	output vic_loader_pkg::blk_mask_t  ram_ext_o,
	output vic_loader_pkg::blk_mask_t  ram_ext_ro_o
);

	vic_loader_pkg::mem_wr_t   ld_wr;
	vic_loader_pkg::addr_t     prg_end;
	vic_loader_pkg::blk_mask_t cart_blk;
	logic                      prg_done;

	image_loader u_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.ld_wr_o    (ld_wr),
		.prg_done_o (prg_done),
		.prg_end_o  (prg_end),
		.cart_blk_o (cart_blk)
	);

	basic_ptr_patcher u_patcher (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ld_wr_i     (ld_wr),
		.prg_done_i  (prg_done),
		.prg_end_i   (prg_end),
		.dl_active_i (dl_i.download),
		.mem_wr_o    (mem_wr_o)
	);

	vic_cfg_regs u_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.paddr_i      (paddr_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.pwdata_i     (pwdata_i),
		.cart_blk_i   (cart_blk),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.ram_ext_o    (ram_ext_o),
		.ram_ext_ro_o (ram_ext_ro_o)
	);

endmodule

`default_nettype wire

// File: vic_loader.f
+incdir+src
src/vic_loader_pkg.sv
src/vic_cfg_regs.sv
src/image_loader.sv
src/basic_ptr_patcher.sv
src/vic_loader_top.sv
sim/tb_vic_checker.sv
sim/tb_vic_loader.sv
